/* logic/ama_riscv_defines.svh */
`ifndef AMA_RISCV_DEFINES_SVH
`define AMA_RISCV_DEFINES_SVH

// architecture widths
`define ARCH_WIDTH 32 // one word
`define ARCH_WIDTH_H 16 // half word
`define ARCH_WIDTH_D 64 // full product

// dot product lane sizes
`define LANE_8 8
`define LANE_16 16

// clocks from accepted input to o_valid
`define MULT_LATENCY 2

`endif

/* logic/ama_riscv_pkg.sv */
`include "ama_riscv_defines.svh"

package ama_riscv_pkg;

// operand or result word
typedef logic [`ARCH_WIDTH-1:0] simd_t;

// double wide product, also one partial product row
typedef logic [`ARCH_WIDTH_D-1:0] simd_d_t;

// multiply ops, bit 2 set for the packed dot products
typedef enum logic [2:0] {
    MULT_OP_MUL = 3'd0, // low word, sign irrelevant
    MULT_OP_MULH = 3'd1, // s x s high word
    MULT_OP_MULHSU = 3'd2, // s x u high word
    MULT_OP_MULHU = 3'd3, // u x u high word
    MULT_OP_DOT16 = 3'd4, // 2 lanes of 16x16
    MULT_OP_DOT8 = 3'd5 // 4 lanes of 8x8
} mult_op_t;

endpackage

/* logic/csa_tree_8.sv */
`timescale 1ns/100ps
`include "ama_riscv_defines.svh"

module csa_tree_8 #(
    parameter int unsigned W = `ARCH_WIDTH_D
) (
    input  logic [7:0][W-1:0] i_a,
    output logic [1:0][W-1:0] o_sc
);

// one row of 3:2 compressors, returns {carry, sum}
// carry already moved up one column
function automatic logic [1:0][W-1:0] csa_3_2(
    input logic [W-1:0] x,
    input logic [W-1:0] y,
    input logic [W-1:0] z
);
    logic [W-1:0] s;
    logic [W-1:0] c;
    s = x ^ y ^ z;
    c = ((x & y) | (x & z) | (y & z)) << 1; // top carry drops, mod 2^W
    return {c, s};
endfunction

logic [W-1:0] sum_r;
logic [W-1:0] car_r;

// chain of six levels, each folds one more input row into sum/carry
always_comb begin
    logic [1:0][W-1:0] sc;
    sum_r = i_a[0];
    car_r = i_a[1];
    for (int k = 2; k < 8; k++) begin
        sc = csa_3_2(sum_r, car_r, i_a[k]);
        sum_r = sc[0];
        car_r = sc[1];
    end
end

assign o_sc[0] = sum_r;
assign o_sc[1] = car_r; // o_sc[0] + o_sc[1] == sum of inputs

endmodule

/* logic/ama_riscv_simd_pp.sv */
`timescale 1ns/100ps
`include "ama_riscv_defines.svh"

module ama_riscv_simd_pp (
    input  ama_riscv_pkg::mult_op_t i_op,
    input  ama_riscv_pkg::simd_t i_a,
    input  ama_riscv_pkg::simd_t i_b,
    output ama_riscv_pkg::simd_d_t [`ARCH_WIDTH-1:0] o_ppv
);

import ama_riscv_pkg::*;

logic op_signed;
int lane_sz; // 8, 16 or full word
int lane_last; // lane_sz - 1, also the lane-local index mask

assign op_signed = (i_op != MULT_OP_MULHU); // only op without BW flips

always_comb begin
    unique case (i_op)
        MULT_OP_DOT8: lane_sz = `LANE_8;
        MULT_OP_DOT16: lane_sz = `LANE_16;
        default: lane_sz = `ARCH_WIDTH; // plain 32x32
    endcase
    lane_last = lane_sz - 1;
end

// row i holds a[i] & b[j] for all j, then moved into its column position
always_comb begin
    for (int i = 0; i < `ARCH_WIDTH; i++) begin
        simd_t row;
        simd_d_t row_d;
        int li; // lane-local row index
        int bi; // lane base of the row

        li = i & lane_last;
        bi = i & ~lane_last;

        for (int j = 0; j < `ARCH_WIDTH; j++) begin
            int lj;
            int bj;
            logic ab;
            logic flip;

            lj = j & lane_last;
            bj = j & ~lane_last;
            ab = i_a[i] & i_b[j];

            // modified BW, invert last lane row and last lane col
            // sign x sign corner stays as is
            flip = op_signed && ((li == lane_last) != (lj == lane_last));

            // keep only the diagonal tile, other lanes must not mix in
            row[j] = (bi == bj) && (ab ^ flip);
        end

        row_d = {{`ARCH_WIDTH{1'b0}}, row};
        // shift by local index, then back by lane base
        // plain mult has base 0 so this is just << i
        o_ppv[i] = (row_d << li) >> bi;
    end
end

// codes 6 and 7 have no datapath behind them
always_comb begin
    assert ($isunknown(i_op) || (i_op inside {
        MULT_OP_MUL, MULT_OP_MULH, MULT_OP_MULHSU,
        MULT_OP_MULHU, MULT_OP_DOT16, MULT_OP_DOT8
    }))
        else $error("ama_riscv_simd_pp: illegal op code %0d", i_op);
end

endmodule

/* logic/ama_riscv_simd_final.sv */
`timescale 1ns/100ps
`include "ama_riscv_defines.svh"

module ama_riscv_simd_final (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_valid,
    input  ama_riscv_pkg::mult_op_t i_op,
    input  ama_riscv_pkg::simd_t i_a,
    input  logic i_b_sign,
    input  ama_riscv_pkg::simd_d_t [7:0] i_rows,
    output logic o_valid,
    output ama_riscv_pkg::simd_t o_p
);

import ama_riscv_pkg::*;

localparam int unsigned DOT8_W = `ARCH_WIDTH_H + 1; // 17 bit dot8 sum
localparam int unsigned DOT8_PAD = `ARCH_WIDTH - DOT8_W; // sign fill, 15 bits

// first stage, tree rows and op context
logic valid_q;
mult_op_t op_q;
simd_t a_q; // needed by MULHSU fixup
logic b_sign_q;
simd_d_t [7:0] rows_q;

always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        valid_q <= 1'b0;
        op_q <= MULT_OP_MUL;
        a_q <= '0;
        b_sign_q <= 1'b0;
        rows_q <= '0;
    end else begin
        valid_q <= i_valid;
        op_q <= i_op;
        a_q <= i_a;
        b_sign_q <= i_b_sign;
        rows_q <= i_rows;
    end
end

// final tree and carry-propagate add
simd_d_t [1:0] tree_sc;
simd_d_t tree_sum;
csa_tree_8 #(.W(`ARCH_WIDTH_D)) csa_tree_8_f (.i_a(rows_q), .o_sc(tree_sc));
assign tree_sum = tree_sc[0] + tree_sc[1];

// BW correction constants
simd_d_t corr;
always_comb begin
    corr = '0;
    unique case (op_q)
        MULT_OP_MUL, MULT_OP_MULH, MULT_OP_MULHSU: begin
            corr[`ARCH_WIDTH] = 1'b1; // 2^n + 2^(2n-1)
            corr[`ARCH_WIDTH_D-1] = 1'b1;
        end
        MULT_OP_DOT16: corr[17] = 1'b1; // 2^16 once per lane, 2^31 terms wrap out
        MULT_OP_DOT8: corr[10] = 1'b1; // 2^8 four times, 2^15 terms above bit 16
        default: corr = '0; // MULHU is a plain unsigned sum
    endcase
end

simd_d_t mul_s;
simd_t mul_su;
assign mul_s = tree_sum + corr;
// s x u = s x s + a * 2^n when b msb set
assign mul_su = b_sign_q ? (mul_s[`ARCH_WIDTH_D-1:`ARCH_WIDTH] + a_q) :
                           mul_s[`ARCH_WIDTH_D-1:`ARCH_WIDTH];

simd_t p_nxt;
always_comb begin
    unique case (op_q)
        MULT_OP_MUL: p_nxt = mul_s[`ARCH_WIDTH-1:0];
        MULT_OP_MULH: p_nxt = mul_s[`ARCH_WIDTH_D-1:`ARCH_WIDTH];
        MULT_OP_MULHSU: p_nxt = mul_su;
        MULT_OP_MULHU: p_nxt = mul_s[`ARCH_WIDTH_D-1:`ARCH_WIDTH]; // corr is 0 here
        MULT_OP_DOT16: p_nxt = mul_s[`ARCH_WIDTH-1:0];
        MULT_OP_DOT8: p_nxt = {{DOT8_PAD{mul_s[DOT8_W-1]}}, mul_s[DOT8_W-1:0]};
        default: p_nxt = '0;
    endcase
end

// output register, second edge
always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_valid <= 1'b0;
        o_p <= '0;
    end else begin
        o_valid <= valid_q;
        o_p <= p_nxt;
    end
end

// valid walks through both stages untouched
assert property (@(posedge clk) disable iff (!i_rst_n)
    ($past(i_rst_n, 1) && $past(i_rst_n, `MULT_LATENCY)) |->
        (o_valid == $past(i_valid, `MULT_LATENCY)));

assert property (@(posedge clk) disable iff (!i_rst_n)
    o_valid |-> !$isunknown(o_p));

endmodule

/* logic/ama_riscv_mult.sv */
`timescale 1ns/100ps
`include "ama_riscv_defines.svh"

module ama_riscv_mult (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_valid,
    input  ama_riscv_pkg::mult_op_t i_op,
    input  ama_riscv_pkg::simd_t i_a,
    input  ama_riscv_pkg::simd_t i_b,
    output logic o_valid,
    output ama_riscv_pkg::simd_t o_p
);

import ama_riscv_pkg::*;

localparam int unsigned N_TREES = `ARCH_WIDTH / 8; // 8 rows per tree

simd_d_t [`ARCH_WIDTH-1:0] ppv; // aligned pp matrix
simd_d_t [2*N_TREES-1:0] tree_rows; // sum/carry pairs, tree k at 2k+1:2k

// partial products, combinational
ama_riscv_simd_pp ama_riscv_simd_pp_i (
    .i_op (i_op),
    .i_a (i_a),
    .i_b (i_b),
    .o_ppv (ppv)
);

// first level trees, rows 8k..8k+7
for (genvar k = 0; k < N_TREES; k++) begin : g_tree
    csa_tree_8 #(
        .W (`ARCH_WIDTH_D)
    ) csa_tree_8_i (
        .i_a (ppv[8*k+7 -: 8]),
        .o_sc (tree_rows[2*k+1 -: 2])
    );
end

// pipeline regs, final tree, add and select
ama_riscv_simd_final ama_riscv_simd_final_i (
    .clk (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_op (i_op),
    .i_a (i_a),
    .i_b_sign (i_b[`ARCH_WIDTH-1]), // only b msb matters past the matrix
    .i_rows (tree_rows),
    .o_valid (o_valid),
    .o_p (o_p)
);

endmodule

/* test/ama_riscv_mult_tb.sv */
`timescale 1ns/100ps
`include "ama_riscv_defines.svh"

module ama_riscv_mult_tb;

import ama_riscv_pkg::*;

localparam int CLK_PERIOD = 4; // ns
localparam int STIM_DLY = 1; // drive point after the rising edge
localparam int RESET_CYC = 5;
localparam int IDLE_CYC = 8; // quiet cycles after reset
localparam int N_MUL = 2000;
localparam int N_DOT16 = 1000;
localparam int N_DOT8 = 1000;
localparam int N_CORNER = 8;
localparam int N_CORNER_OPS = 6 * N_CORNER * N_CORNER;
localparam int N_MIXED = 2000;
localparam int DRAIN_CYC = `MULT_LATENCY + 2;
localparam int TOTAL_CYC = RESET_CYC + IDLE_CYC + N_MUL + N_DOT16 + N_DOT8
                         + N_CORNER_OPS + N_MIXED + DRAIN_CYC;
localparam int WATCHDOG_MARGIN = 100 * CLK_PERIOD;

logic clk = 1'b0;
logic i_rst_n;
logic i_valid;
mult_op_t i_op;
simd_t i_a;
simd_t i_b;
logic o_valid;
simd_t o_p;

int cyc = 0; // rising edges seen so far
logic [31:0] lfsr_state = 32'h9d712104;

// scoreboard with one entry per issued op
simd_t exp_q[$];
string name_q[$];
int due_q[$]; // value of cyc when the result is due

// zero, one, all ones, min, lane mins, max, small lanes
simd_t corner_val [N_CORNER] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
    32'h8000_8000, 32'h8080_8080, 32'h7fff_ffff, 32'h0001_0001
};

ama_riscv_mult uut (
    .clk (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_op (i_op),
    .i_a (i_a),
    .i_b (i_b),
    .o_valid (o_valid),
    .o_p (o_p)
);

always #(CLK_PERIOD / 2) clk = ~clk;

always @(posedge clk) cyc <= cyc + 1;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]}; // one step per bit
    end
endtask

// reference results straight from the op definitions
function automatic simd_t model_result(input mult_op_t op, input simd_t a, input simd_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] prod;
    logic signed [31:0] acc;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    prod = '0;
    acc = '0;
    case (op)
        MULT_OP_MUL: prod = sa * sb;
        MULT_OP_MULH: prod = sa * sb;
        MULT_OP_MULHSU: prod = sa * $signed(ub); // b zero extended
        MULT_OP_MULHU: prod = ua * ub;
        MULT_OP_DOT16: begin
            for (int l = 0; l < 2; l++)
                acc = acc + 32'($signed(a[16*l +: 16])) * 32'($signed(b[16*l +: 16]));
        end
        default: begin
            for (int l = 0; l < 4; l++)
                acc = acc + 32'($signed(a[8*l +: 8])) * 32'($signed(b[8*l +: 8]));
        end
    endcase
    case (op)
        MULT_OP_MUL: return prod[31:0];
        MULT_OP_MULH, MULT_OP_MULHSU, MULT_OP_MULHU: return prod[63:32];
        MULT_OP_DOT16: return acc; // low 32 bits of the lane sum
        default: return {{15{acc[16]}}, acc[16:0]}; // 17 bit dot8 sum
    endcase
endfunction

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input simd_t exp, input simd_t act);
    if (exp !== act) begin
        $display("error: %s expected %h actual %h", name, exp, act);
        abort_run("result mismatch");
    end
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #STIM_DLY;
        i_valid = 1'b0;
    end
endtask

// bubble with live operands and a legal op
task automatic drive_gap(input mult_op_t op, input simd_t a, input simd_t b);
    @(posedge clk);
    #STIM_DLY;
    i_valid = 1'b0;
    i_op = op;
    i_a = a;
    i_b = b;
endtask

task automatic issue_op(input mult_op_t op, input simd_t a, input simd_t b, input string name);
    @(posedge clk);
    #STIM_DLY;
    i_valid = 1'b1;
    i_op = op;
    i_a = a;
    i_b = b;
    exp_q.push_back(model_result(op, a, b));
    name_q.push_back(name);
    due_q.push_back(cyc + `MULT_LATENCY); // latency counted from this drive point
endtask

// sample outputs half a cycle after the edge that updates them
always @(negedge clk) begin
    if (o_valid) begin
        if (exp_q.size() == 0) begin
            abort_run("o_valid went high with no operation in flight");
        end else if (due_q[0] != cyc) begin
            abort_run($sformatf("%s came out on the wrong cycle", name_q[0]));
        end else begin
            check_value(name_q[0], exp_q[0], o_p);
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            void'(due_q.pop_front());
        end
    end else if (exp_q.size() != 0 && due_q[0] == cyc) begin
        abort_run($sformatf("o_valid missing for %s", name_q[0]));
    end
end

initial begin
    #(TOTAL_CYC * CLK_PERIOD + WATCHDOG_MARGIN);
    abort_run("watchdog expired before the tests finished");
end

initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [2:0] code;
    mult_op_t op;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_op = MULT_OP_MUL;
    i_a = '0;
    i_b = '0;
    repeat (RESET_CYC) @(posedge clk);
    #STIM_DLY;
    i_rst_n = 1'b1;
    idle_cycles(IDLE_CYC); // o_valid must stay low here

    // scalar multiplies back to back
    for (int n = 0; n < N_MUL; n++) begin
        draw_bits(2, r);
        draw_bits(32, a);
        draw_bits(32, b);
        op = mult_op_t'({1'b0, r[1:0]});
        issue_op(op, a, b, $sformatf("%s rand", op.name()));
    end
    for (int n = 0; n < N_DOT16; n++) begin
        draw_bits(32, a);
        draw_bits(32, b);
        issue_op(MULT_OP_DOT16, a, b, "MULT_OP_DOT16 rand");
    end
    for (int n = 0; n < N_DOT8; n++) begin
        draw_bits(32, a);
        draw_bits(32, b);
        issue_op(MULT_OP_DOT8, a, b, "MULT_OP_DOT8 rand");
    end

    // every op on every corner pair including sign x sign
    for (int o = 0; o < 6; o++) begin
        op = mult_op_t'(3'(o));
        for (int ia = 0; ia < N_CORNER; ia++)
            for (int ib = 0; ib < N_CORNER; ib++)
                issue_op(op, corner_val[ia], corner_val[ib],
                         $sformatf("%s corner %h %h", op.name(), corner_val[ia],
                                   corner_val[ib]));
    end

    // mixed ops with valid gaps
    for (int n = 0; n < N_MIXED; n++) begin
        draw_bits(1, v);
        draw_bits(3, r);
        draw_bits(32, a);
        draw_bits(32, b);
        code = 3'(r % 6);
        op = mult_op_t'(code);
        if (v[0])
            issue_op(op, a, b, $sformatf("%s mixed", op.name()));
        else
            drive_gap(op, a, b);
    end

    idle_cycles(DRAIN_CYC);
    if (exp_q.size() == 0) begin
        $display("Simulation passed");
        $finish;
    end else begin
        abort_run($sformatf("%0d operations never produced a result", exp_q.size()));
    end
end

endmodule

/* flist.f */
+incdir+logic
logic/ama_riscv_pkg.sv
logic/csa_tree_8.sv
logic/ama_riscv_simd_pp.sv
logic/ama_riscv_simd_final.sv
logic/ama_riscv_mult.sv
test/ama_riscv_mult_tb.sv

/* run.sh */
#!/usr/bin/env bash
# lint, build and run the multiply unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=ama_riscv_mult_tb
VFLAGS="--timing --assert -f flist.f --top-module ${TOP}"

verilator --lint-only ${VFLAGS}
if [ $? -ne 0 ]; then
    echo "lint failed"
    exit 1
fi

verilator --binary ${VFLAGS} -Mdir obj_dir -o ${TOP}
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/${TOP}
status=$?
if [ ${status} -ne 0 ]; then
    echo "simulation exited with status ${status}"
    exit ${status}
fi
exit 0
